// ==== source/sad_pkg.sv ====
package sad_pkg;

  // pixel and sum widths
  localparam int PixelWidth = 8;
  localparam int SadWidth   = 17;  // 255 * 256 fits

  // memory address widths
  localparam int SAddrWidth = 10;  // search windows up to 32 x 32
  localparam int RAddrWidth = 8;

  // one pixel as read from either memory
  typedef logic [PixelWidth-1:0] pixel_t;

  // accumulated sum of absolute differences
  typedef logic [SadWidth-1:0] sad_t;

  // linear row-major search memory address
  typedef logic [SAddrWidth-1:0] saddr_t;

  // linear row-major reference memory address
  typedef logic [RAddrWidth-1:0] raddr_t;

endpackage

// ==== source/sad_scan_decode.sv ====
`timescale 1ns/1ns

module sad_scan_decode import sad_pkg::*; #(
  parameter int SImgSize = 19,
  parameter int RImgSize = 4,
  parameter int PeNum    = 8
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   start_i,
  input  logic   finish_i,
  output logic   busy_o,
  output saddr_t smem_raddr_o,
  output raddr_t ref_raddr_o,
  output logic   beat_valid_o,
  output logic   ref_valid_o,
  output logic   first_beat_o,
  output logic   strip_last_o,
  output logic   job_last_o,
  output saddr_t strip_base_o
);

  localparam int BeatNum = RImgSize + PeNum - 1;   // beats per reference row
  localparam int CandNum = SImgSize - RImgSize + 1; // candidates per axis
  localparam int GrpNum  = CandNum / PeNum;         // strips per candidate row
  localparam int BeatW   = $clog2(BeatNum + 1);
  localparam int RowW    = $clog2(RImgSize + 1);
  localparam int GrpW    = $clog2(GrpNum + 1);
  localparam int CandW   = $clog2(CandNum + 1);

  localparam saddr_t RowStep  = SAddrWidth'(SImgSize);
  localparam saddr_t GrpStep  = SAddrWidth'(PeNum);
  localparam saddr_t WrapStep = SAddrWidth'(BeatNum); // last strip of a row to next row

  logic             active;   // beats still being issued
  logic [BeatW-1:0] beat_cnt;
  logic [RowW-1:0]  row_cnt;
  logic [GrpW-1:0]  grp_cnt;
  logic [CandW-1:0] cand_row;
  saddr_t           row_addr;   // first search address of current reference row
  saddr_t           strip_base;
  saddr_t           next_base;
  logic             beat_last;
  logic             row_last;
  logic             grp_last;
  logic             cand_last;
  logic             strip_end;
  logic             job_end;

  always_comb begin
    beat_last = beat_cnt == BeatW'(BeatNum - 1);
    row_last  = row_cnt == RowW'(RImgSize - 1);
    grp_last  = grp_cnt == GrpW'(GrpNum - 1);
    cand_last = cand_row == CandW'(CandNum - 1);
    strip_end = beat_last && row_last;
    job_end   = strip_end && grp_last && cand_last;
    if (job_end) begin
      next_base = '0;  // park at 0 for the next job
    end else if (grp_last) begin
      next_base = strip_base + WrapStep;
    end else begin
      next_base = strip_base + GrpStep;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_o       <= 1'b0;
      active       <= 1'b0;
      beat_cnt     <= '0;
      row_cnt      <= '0;
      grp_cnt      <= '0;
      cand_row     <= '0;
      row_addr     <= '0;
      strip_base   <= '0;
      smem_raddr_o <= '0;
      ref_raddr_o  <= '0;
      beat_valid_o <= 1'b0;
      ref_valid_o  <= 1'b0;
      first_beat_o <= 1'b0;
      strip_last_o <= 1'b0;
      job_last_o   <= 1'b0;
      strip_base_o <= '0;
    end else begin
      // flags follow the address by one cycle to stay in step with the read data
      beat_valid_o <= active;
      ref_valid_o  <= beat_cnt < BeatW'(RImgSize);
      first_beat_o <= active && (beat_cnt == '0) && (row_cnt == '0);
      strip_last_o <= active && strip_end;
      job_last_o   <= active && job_end;
      strip_base_o <= strip_base;

      if (finish_i) begin
        busy_o <= 1'b0;
      end

      if (start_i && !busy_o) begin
        busy_o <= 1'b1;
        active <= 1'b1;  // counters and addresses already sit at 0
      end else if (active) begin
        if (!beat_last) begin
          beat_cnt     <= beat_cnt + 1'b1;
          smem_raddr_o <= smem_raddr_o + 1'b1;
          if (beat_cnt < BeatW'(RImgSize - 1)) begin
            ref_raddr_o <= ref_raddr_o + 1'b1;
          end
        end else if (!row_last) begin
          beat_cnt     <= '0;
          row_cnt      <= row_cnt + 1'b1;
          row_addr     <= row_addr + RowStep;
          smem_raddr_o <= row_addr + RowStep;
          ref_raddr_o  <= ref_raddr_o + 1'b1;
        end else begin
          beat_cnt     <= '0;
          row_cnt      <= '0;
          ref_raddr_o  <= '0;
          strip_base   <= next_base;
          row_addr     <= next_base;
          smem_raddr_o <= next_base;
          grp_cnt      <= grp_last ? '0 : grp_cnt + 1'b1;
          if (grp_last) begin
            cand_row <= cand_last ? '0 : cand_row + 1'b1;
          end
          if (job_end) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== source/sad_pe_array.sv ====
`timescale 1ns/1ns

module sad_pe_array import sad_pkg::*; #(
  parameter int PeNum = 8
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   beat_valid_i,
  input  logic   ref_valid_i,
  input  logic   first_beat_i,
  input  logic   strip_last_i,
  input  logic   job_last_i,
  input  saddr_t strip_base_i,
  input  pixel_t search_pix_i,
  input  pixel_t ref_pix_i,
  output sad_t   sad_o [PeNum],
  output logic   done_o,
  output logic   job_done_o,
  output saddr_t base_o
);

  pixel_t stage_pix   [PeNum];  // stage k feeds element k
  logic   stage_vld   [PeNum];
  logic   stage_first [PeNum];
  pixel_t dly_pix     [PeNum-1];
  logic   dly_vld     [PeNum-1];
  logic   dly_first   [PeNum-1];
  sad_t   acc         [PeNum];
  logic   strip_last_q;
  logic   job_last_q;
  saddr_t base_q;

  function automatic pixel_t abs_diff(pixel_t a, pixel_t b);
    return (a > b) ? a - b : b - a;
  endfunction

  always_comb begin
    stage_pix[0]   = ref_pix_i;
    stage_vld[0]   = beat_valid_i && ref_valid_i;
    stage_first[0] = first_beat_i;
    for (int k = 1; k < PeNum; k++) begin
      stage_pix[k]   = dly_pix[k-1];
      stage_vld[k]   = dly_vld[k-1];
      stage_first[k] = dly_first[k-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int k = 0; k < PeNum - 1; k++) begin
        dly_vld[k]   <= 1'b0;
        dly_first[k] <= 1'b0;
      end
      strip_last_q <= 1'b0;
      job_last_q   <= 1'b0;
      done_o       <= 1'b0;
      job_done_o   <= 1'b0;
    end else begin
      for (int k = 0; k < PeNum - 1; k++) begin
        dly_vld[k]   <= stage_vld[k];
        dly_first[k] <= stage_first[k];
      end
      strip_last_q <= strip_last_i;  // last element takes its final term here
      job_last_q   <= job_last_i;
      done_o       <= strip_last_q;
      job_done_o   <= job_last_q;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < PeNum - 1; k++) begin
      dly_pix[k] <= stage_pix[k];
    end
    for (int k = 0; k < PeNum; k++) begin
      if (stage_vld[k]) begin
        if (stage_first[k]) begin
          acc[k] <= SadWidth'(abs_diff(search_pix_i, stage_pix[k]));
        end else begin
          acc[k] <= acc[k] + SadWidth'(abs_diff(search_pix_i, stage_pix[k]));
        end
      end
    end
    base_q <= strip_base_i;
    // element 0 restarts on this same edge, so the sums are snapshotted
    if (strip_last_q) begin
      sad_o  <= acc;
      base_o <= base_q;
    end
  end

endmodule

// ==== source/sad_min_select.sv ====
`timescale 1ns/1ns

module sad_min_select import sad_pkg::*; #(
  parameter int PeNum = 8
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   done_i,
  input  logic   job_done_i,
  input  sad_t   sad_i [PeNum],
  input  saddr_t base_i,
  output logic   finish_o,
  output sad_t   min_sad_o,
  output saddr_t min_addr_o
);

  localparam int NodeNum = 2 * PeNum - 1;  // heap layout with leaves at the back

  sad_t   best_sad  [PeNum];
  saddr_t best_addr [PeNum];
  sad_t   next_sad  [PeNum];
  saddr_t next_addr [PeNum];
  sad_t   tree_sad  [NodeNum];
  saddr_t tree_addr [NodeNum];
  logic   first_strip;  // next done opens a new job
  logic   take_right;

  always_comb begin
    for (int k = 0; k < PeNum; k++) begin
      next_sad[k]  = best_sad[k];
      next_addr[k] = best_addr[k];
      // strictly smaller keeps the earlier, lower address on a tie
      if (done_i && (first_strip || sad_i[k] < best_sad[k])) begin
        next_sad[k]  = sad_i[k];
        next_addr[k] = base_i + SAddrWidth'(k);
      end
    end
  end

  always_comb begin
    take_right = 1'b0;
    for (int k = 0; k < PeNum; k++) begin
      tree_sad[PeNum-1+k]  = next_sad[k];
      tree_addr[PeNum-1+k] = next_addr[k];
    end
    for (int i = PeNum - 2; i >= 0; i--) begin
      take_right = (tree_sad[2*i+2] < tree_sad[2*i+1]) ||
                   ((tree_sad[2*i+2] == tree_sad[2*i+1]) &&
                    (tree_addr[2*i+2] < tree_addr[2*i+1]));
      if (take_right) begin
        tree_sad[i]  = tree_sad[2*i+2];
        tree_addr[i] = tree_addr[2*i+2];
      end else begin
        tree_sad[i]  = tree_sad[2*i+1];
        tree_addr[i] = tree_addr[2*i+1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < PeNum; k++) begin
      best_sad[k]  <= next_sad[k];
      best_addr[k] <= next_addr[k];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      first_strip <= 1'b1;
      finish_o    <= 1'b0;
      min_sad_o   <= '0;
      min_addr_o  <= '0;
    end else begin
      finish_o <= job_done_i;
      if (job_done_i) begin
        first_strip <= 1'b1;
        min_sad_o   <= tree_sad[0];  // root of the tree
        min_addr_o  <= tree_addr[0];
      end else if (done_i) begin
        first_strip <= 1'b0;
      end
    end
  end

endmodule

// ==== source/motion_search_top.sv ====
`timescale 1ns/1ns

module motion_search_top import sad_pkg::*; #(
  parameter int SImgSize = 19,
  parameter int RImgSize = 4,
  parameter int PeNum    = 8
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   start_i,
  input  pixel_t smem_rdata_i,
  input  pixel_t ref_rdata_i,
  output saddr_t smem_raddr_o,
  output raddr_t ref_raddr_o,
  output logic   busy_o,
  output logic   finish_o,
  output sad_t   min_sad_o,
  output saddr_t min_addr_o
);

  // decode to execute
  logic   beat_valid;
  logic   ref_valid;
  logic   first_beat;
  logic   strip_last;
  logic   job_last;
  saddr_t strip_base;

  // execute to result
  sad_t   pe_sad [PeNum];
  logic   strip_done;
  logic   job_done;
  saddr_t done_base;

  sad_scan_decode #(
    .SImgSize(SImgSize),
    .RImgSize(RImgSize),
    .PeNum   (PeNum)
  ) i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .finish_i    (finish_o),
    .busy_o      (busy_o),
    .smem_raddr_o(smem_raddr_o),
    .ref_raddr_o (ref_raddr_o),
    .beat_valid_o(beat_valid),
    .ref_valid_o (ref_valid),
    .first_beat_o(first_beat),
    .strip_last_o(strip_last),
    .job_last_o  (job_last),
    .strip_base_o(strip_base)
  );

  sad_pe_array #(
    .PeNum(PeNum)
  ) i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .beat_valid_i(beat_valid),
    .ref_valid_i (ref_valid),
    .first_beat_i(first_beat),
    .strip_last_i(strip_last),
    .job_last_i  (job_last),
    .strip_base_i(strip_base),
    .search_pix_i(smem_rdata_i),  // broadcast to all elements
    .ref_pix_i   (ref_rdata_i),
    .sad_o       (pe_sad),
    .done_o      (strip_done),
    .job_done_o  (job_done),
    .base_o      (done_base)
  );

  sad_min_select #(
    .PeNum(PeNum)
  ) i_result (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .done_i    (strip_done),
    .job_done_i(job_done),
    .sad_i     (pe_sad),
    .base_i    (done_base),
    .finish_o  (finish_o),
    .min_sad_o (min_sad_o),
    .min_addr_o(min_addr_o)
  );

endmodule

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// sad of the candidate whose top-left pixel sits at column x0, row y0
function automatic int cand_sad(input int x0, input int y0);
  int sum;
  int s_pix;
  int r_pix;
  sum = 0;
  for (int ry = 0; ry < RImg; ry++) begin
    for (int rx = 0; rx < RImg; rx++) begin
      s_pix = int'(smem[saddr_t'((y0 + ry) * SImg + x0 + rx)]);
      r_pix = int'(rmem[raddr_t'(ry * RImg + rx)]);
      sum += (s_pix > r_pix) ? s_pix - r_pix : r_pix - s_pix;
    end
  end
  return sum;
endfunction

// exhaustive search over all candidates
// row-major scan with a strict compare keeps the lowest address on a tie
task automatic find_best(output int best_sad, output int best_addr);
  int sad;
  best_sad  = -1;
  best_addr = 0;
  for (int y0 = 0; y0 < CandNum; y0++) begin
    for (int x0 = 0; x0 < CandNum; x0++) begin
      sad = cand_sad(x0, y0);
      if (best_sad < 0 || sad < best_sad) begin
        best_sad  = sad;
        best_addr = y0 * SImg + x0;
      end
    end
  end
endtask

`endif

// ==== sim/tb_motion_search.sv ====
`timescale 1ns/1ns

module tb_motion_search import sad_pkg::*; ();

  localparam int SImg          = 19;
  localparam int RImg          = 4;
  localparam int PeCnt         = 8;
  localparam int CandNum       = SImg - RImg + 1;
  localparam int ScanLen       = CandNum * (CandNum / PeCnt) * RImg * (RImg + PeCnt - 1) + 16;
  localparam int NumRuns       = 4;
  localparam int TimeoutCycles = 2 * NumRuns * ScanLen + 500;
  localparam int ClkPeriod     = 20;

  logic   clk        = 1'b0;
  logic   rst_n      = 1'b0;
  logic   start      = 1'b0;
  pixel_t smem_rdata = '0;
  pixel_t ref_rdata  = '0;
  saddr_t smem_raddr;
  raddr_t ref_raddr;
  logic   busy;
  logic   finish;
  sad_t   min_sad;
  saddr_t min_addr;

  pixel_t smem [1 << SAddrWidth];  // search window in row-major order
  pixel_t rmem [1 << RAddrWidth];  // reference block in row-major order
  saddr_t saddr_smp = '0;
  raddr_t raddr_smp = '0;
  int     seed      = 82;
  int     cycle_cnt = 0;

  `include "tb_ref_model.svh"

  motion_search_top #(
    .SImgSize(SImg),
    .RImgSize(RImg),
    .PeNum   (PeCnt)
  ) i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .start_i     (start),
    .smem_rdata_i(smem_rdata),
    .ref_rdata_i (ref_rdata),
    .smem_raddr_o(smem_raddr),
    .ref_raddr_o (ref_raddr),
    .busy_o      (busy),
    .finish_o    (finish),
    .min_sad_o   (min_sad),
    .min_addr_o  (min_addr)
  );

  initial begin
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // synchronous read with data one cycle after the address
  always @(negedge clk) begin
    saddr_smp = smem_raddr;
    raddr_smp = ref_raddr;
  end

  always @(posedge clk) begin
    #2;
    smem_rdata = smem[saddr_smp];
    ref_rdata  = rmem[raddr_smp];
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TimeoutCycles) begin
      stop_with_error($sformatf("timeout: no result after %0d cycles, the DUT hangs", cycle_cnt));
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic fill_random();
    for (int a = 0; a < (1 << SAddrWidth); a++) begin
      smem[saddr_t'(a)] = pixel_t'($random(seed));
    end
    for (int a = 0; a < (1 << RAddrWidth); a++) begin
      rmem[raddr_t'(a)] = pixel_t'($random(seed));
    end
  endtask

  task automatic fill_flat(input pixel_t value);
    for (int a = 0; a < (1 << SAddrWidth); a++) begin
      smem[saddr_t'(a)] = value;
    end
    for (int a = 0; a < (1 << RAddrWidth); a++) begin
      rmem[raddr_t'(a)] = value;
    end
  endtask

  // copies the reference block into the window at a random candidate
  task automatic plant_block();
    int px;
    int py;
    px = ($random(seed) & 32'h7fff_ffff) % CandNum;
    py = ($random(seed) & 32'h7fff_ffff) % CandNum;
    for (int ry = 0; ry < RImg; ry++) begin
      for (int rx = 0; rx < RImg; rx++) begin
        smem[saddr_t'((py + ry) * SImg + px + rx)] = rmem[raddr_t'(ry * RImg + rx)];
      end
    end
  endtask

  task automatic run_search(input int exp_sad, input int exp_addr, input bit pulse_again);
    int cycles;
    assert (busy == 1'b0)
      else stop_with_error($sformatf("ERR %0t: busy_o high before start", $time));
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    assert (busy == 1'b1)
      else stop_with_error($sformatf("ERR %0t: busy_o not set after start", $time));
    cycles = 0;
    while (finish !== 1'b1) begin
      assert (busy == 1'b1) else stop_with_error($sformatf("ERR %0t: busy_o fell early", $time));
      start = pulse_again && (cycles == 100);  // must be ignored while busy
      next_cycle();
      cycles++;
    end
    start = 1'b0;
    assert (min_sad == sad_t'(exp_sad)) else stop_with_error($sformatf(
        "ERR %0t: min_sad_o is %0d, expected %0d", $time, min_sad, exp_sad));
    assert (min_addr == saddr_t'(exp_addr)) else stop_with_error($sformatf(
        "ERR %0t: min_addr_o is %0d, expected %0d", $time, min_addr, exp_addr));
    assert (busy == 1'b1) else stop_with_error($sformatf("ERR %0t: busy_o low at finish", $time));
    next_cycle();
    assert (busy == 1'b0)
      else stop_with_error($sformatf("ERR %0t: busy_o high after finish", $time));
    repeat (20) begin
      assert (finish == 1'b0)
        else stop_with_error($sformatf("ERR %0t: extra finish_o pulse", $time));
      assert (busy == 1'b0)
        else stop_with_error($sformatf("ERR %0t: busy_o set while idle", $time));
      next_cycle();
    end
  endtask

  initial begin
    int exp_sad;
    int exp_addr;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    assert (busy == 1'b0 && finish == 1'b0 && min_sad == '0 && min_addr == '0)
      else stop_with_error($sformatf("ERR %0t: outputs not cleared by reset", $time));
    assert (smem_raddr == '0 && ref_raddr == '0)
      else stop_with_error($sformatf("ERR %0t: read addresses not 0 after reset", $time));

    for (int run = 0; run < NumRuns; run++) begin
      fill_random();
      find_best(exp_sad, exp_addr);
      run_search(exp_sad, exp_addr, 1'b0);
    end

    fill_random();
    plant_block();
    find_best(exp_sad, exp_addr);
    run_search(0, exp_addr, 1'b0);  // an exact copy sums to 0

    fill_random();
    find_best(exp_sad, exp_addr);
    run_search(exp_sad, exp_addr, 1'b1);

    fill_flat(pixel_t'($random(seed)));  // every candidate ties at 0
    run_search(0, 0, 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
source/sad_pkg.sv
source/sad_scan_decode.sv
source/sad_pe_array.sv
source/sad_min_select.sv
source/motion_search_top.sv
sim/tb_motion_search.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_motion_search -o tb_motion_search
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_motion_search 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if echo "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
